// File: design/snd_cpu.sv
// three-byte instruction sequencer standing in for the sound cpu; drives held bus requests
`default_nettype none

module snd_cpu (
    input  wire                clk,
    input  wire                rst_n,
    input  wire                nmi_n,   // active low, pending from decode
    input  wire                rdy,     // one-cycle ack of the held request
    input  wire  [7:0]         rdata,
    output snd_pkg::bus_req_t  req
);
    import snd_pkg::*;

    typedef enum logic [2:0] {
        ST_FETCH0,   // opcode
        ST_FETCH1,   // b1
        ST_FETCH2,   // b2
        ST_EXEC,
        ST_NMI       // save pc, jump to vector
    } state_t;

    state_t      state;
    state_t      boundary;  // where an instruction ends up next
    logic [15:0] pc;
    logic [15:0] saved_pc;
    logic [7:0]  a;
    logic [7:0]  op_q;
    logic [7:0]  b1;
    logic [7:0]  b2;
    logic        in_nmi;
    op_t         op;
    logic [15:0] operand;
    logic        exec_bus;  // instruction needs a data access

    assign op       = op_t'(op_q);   // unknown bytes fall to default = nop
    assign operand  = {b2, b1};      // little endian
    assign exec_bus = (op == OP_LD) || (op == OP_ST) || (op == OP_IN) || (op == OP_OUT);

    // nmi only between instructions and never nested
    assign boundary = (!nmi_n && !in_nmi) ? ST_NMI : ST_FETCH0;

    always_comb begin
        req       = '0;          // idle: mreq and iorq low
        req.addr  = pc;
        req.wdata = a;
        case (state)
            ST_FETCH0, ST_FETCH1, ST_FETCH2: begin
                req.mreq = 1'b1;
                req.rd   = 1'b1;
            end
            ST_EXEC: begin
                case (op)
                    OP_LD: begin
                        req.addr = operand;
                        req.mreq = 1'b1;
                        req.rd   = 1'b1;
                    end
                    OP_ST: begin
                        req.addr = operand;
                        req.mreq = 1'b1;
                        req.wr   = 1'b1;
                    end
                    OP_IN: begin
                        req.addr = {8'h00, b1};   // port in low byte
                        req.iorq = 1'b1;
                        req.rd   = 1'b1;
                    end
                    OP_OUT: begin
                        req.addr = {8'h00, b1};
                        req.iorq = 1'b1;
                        req.wr   = 1'b1;
                    end
                    default: ;                     // no bus cycle
                endcase
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= ST_FETCH0;
            pc     <= '0;        // first fetch at 0
            in_nmi <= 1'b0;
        end else begin
            case (state)
                ST_FETCH0: if (rdy) begin
                    op_q  <= rdata;
                    pc    <= pc + 16'd1;
                    state <= ST_FETCH1;
                end
                ST_FETCH1: if (rdy) begin
                    b1    <= rdata;
                    pc    <= pc + 16'd1;
                    state <= ST_FETCH2;
                end
                ST_FETCH2: if (rdy) begin
                    b2    <= rdata;
                    pc    <= pc + 16'd1;
                    state <= ST_EXEC;
                end
                ST_EXEC: if (!exec_bus || rdy) begin
                    state <= boundary;
                    case (op)
                        OP_LDI:       a <= b1;
                        OP_LD, OP_IN: a <= rdata;
                        OP_JP:        pc <= operand;
                        OP_RETN: begin
                            pc     <= saved_pc;
                            in_nmi <= 1'b0;
                        end
                        default: ;             // nop, st, out
                    endcase
                end
                ST_NMI: begin
                    saved_pc <= pc;            // pc already points past the instruction
                    pc       <= NMI_VEC;
                    in_nmi   <= 1'b1;
                    state    <= ST_FETCH0;
                end
                default: state <= ST_FETCH0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/snd_decode.sv
// registered address decode, read mux, rom ok qualification and nmi flip-flop of the sound board
`default_nettype none

module snd_decode #(
    parameter int RAM_AW = snd_pkg::SND_RAM_AW
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire snd_pkg::bus_req_t      req,
    input  wire  [7:0]                  rom_data,
    input  wire                         rom_ok,
    input  wire  [7:0]                  latch,     // command from main board
    input  wire                         irqn,      // rising edge raises nmi
    input  wire  [7:0]                  ram_dout,
    input  wire  [7:0]                  tone_dout,
    output logic                        rdy,
    output logic [7:0]                  rdata,
    output logic                        nmi_n,
    output logic [snd_pkg::ROM_AW-1:0]  rom_addr,
    output logic                        rom_cs,
    output logic                        ram_we,
    output logic [RAM_AW-1:0]           ram_addr,
    output logic                        tone_cs,
    output logic                        tone_we
);
    import snd_pkg::*;

    logic active;
    logic is_rom, is_ram, is_latch, is_tone, is_pcm, is_open;
    logic ram_cs, latch_cs, pcm_cs, open_cs;
    logic rdy_q;     // ready for fixed-latency targets
    logic rom_ok2;   // rom_ok one cycle late
    logic irqn_q;
    logic nmi_pend;

    assign active   = (req.mreq | req.iorq) & (req.rd | req.wr);
    assign is_rom   = req.mreq & ~req.addr[15];
    assign is_ram   = req.mreq & (req.addr[15:RAM_AW] == RAM_BASE[15:RAM_AW]);
    assign is_latch = (req.mreq & (req.addr[15:11] == LATCH_ADDR[15:11]))   // e800
                    | (req.iorq & (req.addr[7:6] == PORT_LATCH));           // c0
    assign is_tone  = req.iorq & (req.addr[7:6] == PORT_TONE);
    assign is_pcm   = req.iorq & (req.addr[7:6] == PORT_PCM);               // 80
    assign is_open  = ~(is_rom | is_ram | is_latch | is_tone | is_pcm);

    // selects register one cycle after the request, dropped after rdy
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rom_cs   <= 1'b0;
            ram_cs   <= 1'b0;
            latch_cs <= 1'b0;
            tone_cs  <= 1'b0;
            pcm_cs   <= 1'b0;
            open_cs  <= 1'b0;
            rdy_q    <= 1'b0;
            rom_ok2  <= 1'b0;
            irqn_q   <= 1'b1;    // no false edge out of reset
            nmi_pend <= 1'b0;
        end else begin
            rom_cs   <= active & is_rom   & ~rdy;
            ram_cs   <= active & is_ram   & ~rdy;
            latch_cs <= active & is_latch & ~rdy;
            tone_cs  <= active & is_tone  & ~rdy;
            pcm_cs   <= active & is_pcm   & ~rdy;
            open_cs  <= active & is_open  & ~rdy;
            rdy_q    <= (ram_cs | latch_cs | tone_cs | pcm_cs | open_cs) & ~rdy;
            rom_ok2  <= rom_ok;
            irqn_q   <= irqn;
            if (latch_cs)
                nmi_pend <= 1'b0;                // reading the latch acks
            else if (irqn && !irqn_q)
                nmi_pend <= 1'b1;
        end
    end

    // rom waits for ok seen two cycles in a row
    assign rdy = rdy_q | (rom_cs & rom_ok & rom_ok2);

    always_comb begin
        if (rom_cs)        rdata = rom_data;
        else if (ram_cs)   rdata = ram_dout;
        else if (tone_cs)  rdata = tone_dout;
        else if (latch_cs) rdata = latch;
        else               rdata = OPEN_BUS;     // pcm port and unmapped
    end

    assign nmi_n    = ~nmi_pend;
    assign rom_addr = req.addr[ROM_AW-1:0];
    assign ram_addr = req.addr[RAM_AW-1:0];
    assign ram_we   = ram_cs  & req.wr & rdy;   // write lands with rdy
    assign tone_we  = tone_cs & req.wr & rdy;

endmodule

`default_nettype wire

// File: design/snd_pkg.sv
// sound board shared definitions: memory map, bus request, opcodes, tone registers; import per module
`default_nettype none

package snd_pkg;

    localparam int SND_RAM_AW     = 11;   // 2 KB work ram
    localparam int SND_SAMPLE_DIV = 16;   // cen_fm ticks per sample
    localparam int ROM_AW         = 15;   // program rom window, A15 low

    // memory map
    localparam logic [15:0] NMI_VEC    = 16'h0066;
    localparam logic [15:0] RAM_BASE   = 16'hF800;  // F800-FFFF
    localparam logic [15:0] LATCH_ADDR = 16'hE800;  // command latch, memory side
    localparam logic [7:0]  OPEN_BUS   = 8'hFF;

    // i/o port ranges on port bits 7:6
    localparam logic [1:0] PORT_TONE  = 2'd0;  // bit 0 picks addr/data
    localparam logic [1:0] PORT_PCM   = 2'd2;  // not fitted
    localparam logic [1:0] PORT_LATCH = 2'd3;

    // sequencer bus request, held until rdy
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        mreq;
        logic        iorq;
        logic        rd;
        logic        wr;
    } bus_req_t;

    typedef enum logic [7:0] {
        OP_NOP  = 8'h00,
        OP_LDI  = 8'h01,  // a = b1
        OP_LD   = 8'h02,  // a = mem[{b2,b1}]
        OP_ST   = 8'h03,  // mem[{b2,b1}] = a
        OP_IN   = 8'h04,  // a = io[b1]
        OP_OUT  = 8'h05,  // io[b1] = a
        OP_JP   = 8'h06,  // pc = {b2,b1}
        OP_RETN = 8'h07   // back from nmi handler
    } op_t;

    typedef enum logic [7:0] {
        REG_C0_PLO = 8'h00,
        REG_C0_PHI = 8'h01,
        REG_C0_VOL = 8'h02,
        REG_C1_PLO = 8'h04,
        REG_C1_PHI = 8'h05,
        REG_C1_VOL = 8'h06,
        REG_PAN    = 8'h08   // bit0/1 ch0 l/r, bit2/3 ch1 l/r
    } tone_reg_t;

endpackage

`default_nettype wire

// File: design/snd_ram.sv
// sound cpu work ram, single port with registered read
`default_nettype none

module snd_ram #(
    parameter int RAM_AW = 11
) (
    input  wire               clk,
    input  wire               we,
    input  wire  [RAM_AW-1:0] addr,
    input  wire  [7:0]        din,
    output logic [7:0]        dout
);

    logic [7:0] mem [2**RAM_AW];

    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= din;
        dout <= mem[addr];   // old data on a write cycle
    end

endmodule

`default_nettype wire

// File: design/snd_top.sv
// sound board top: sequencer, decode, work ram and tone generator wired together
`default_nettype none

module snd_top #(
    parameter int RAM_AW     = snd_pkg::SND_RAM_AW,
    parameter int SAMPLE_DIV = snd_pkg::SND_SAMPLE_DIV
) (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         cen_fm,    // tone generator only
    input  wire  [7:0]                  latch,
    input  wire                         irqn,
    input  wire  [7:0]                  rom_data,
    input  wire                         rom_ok,
    output wire  [snd_pkg::ROM_AW-1:0]  rom_addr,
    output wire                         rom_cs,
    output wire signed [15:0]           left,
    output wire signed [15:0]           right,
    output wire                         sample
);
    import snd_pkg::*;

    bus_req_t          req;
    logic              rdy;
    logic              nmi_n;
    logic [7:0]        rdata;
    logic              ram_we;
    logic [RAM_AW-1:0] ram_addr;
    logic [7:0]        ram_dout;
    logic              tone_cs;
    logic              tone_we;
    logic [7:0]        tone_dout;

    snd_cpu u_cpu (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .nmi_n ( nmi_n ),
        .rdy   ( rdy   ),
        .rdata ( rdata ),
        .req   ( req   )
    );

    snd_decode #(.RAM_AW(RAM_AW)) u_decode (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .req       ( req       ),
        .rom_data  ( rom_data  ),
        .rom_ok    ( rom_ok    ),
        .latch     ( latch     ),
        .irqn      ( irqn      ),
        .ram_dout  ( ram_dout  ),
        .tone_dout ( tone_dout ),
        .rdy       ( rdy       ),
        .rdata     ( rdata     ),
        .nmi_n     ( nmi_n     ),
        .rom_addr  ( rom_addr  ),
        .rom_cs    ( rom_cs    ),
        .ram_we    ( ram_we    ),
        .ram_addr  ( ram_addr  ),
        .tone_cs   ( tone_cs   ),
        .tone_we   ( tone_we   )
    );

    snd_ram #(.RAM_AW(RAM_AW)) u_ram (
        .clk  ( clk       ),
        .we   ( ram_we    ),
        .addr ( ram_addr  ),
        .din  ( req.wdata ),
        .dout ( ram_dout  )
    );

    tone_gen #(.SAMPLE_DIV(SAMPLE_DIV)) u_tone (
        .clk    ( clk         ),
        .rst_n  ( rst_n       ),
        .cen_fm ( cen_fm      ),
        .cs     ( tone_cs     ),
        .we     ( tone_we     ),
        .a0     ( req.addr[0] ),   // port bit 0: addr or data
        .din    ( req.wdata   ),
        .dout   ( tone_dout   ),
        .sample ( sample      ),
        .left   ( left        ),
        .right  ( right       )
    );

endmodule

`default_nettype wire

// File: design/tone_gen.sv
// two-channel square tone generator behind an fm-style address/data port, with panning and sample strobe
`default_nettype none

module tone_gen #(
    parameter int SAMPLE_DIV = snd_pkg::SND_SAMPLE_DIV
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               cen_fm,
    input  wire               cs,
    input  wire               we,
    input  wire               a0,      // 0 register number, 1 data
    input  wire        [7:0]  din,
    output logic       [7:0]  dout,
    output logic              sample,
    output logic signed [15:0] left,
    output logic signed [15:0] right
);
    import snd_pkg::*;

    localparam int DIV_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

    tone_reg_t         reg_sel;
    logic [15:0]       period [2];
    logic [6:0]        vol    [2];
    logic [15:0]       cnt    [2];
    logic [1:0]        phase;
    logic [3:0]        pan;
    logic [DIV_W-1:0]  div;
    logic              tick;
    logic signed [15:0] amp    [2];
    logic signed [15:0] ch_val [2];
    logic signed [15:0] mix_l, mix_r;
    logic [7:0]        rd_val;

    assign tick = cen_fm && (div == DIV_W'(SAMPLE_DIV - 1));

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            amp[i] = {2'b00, vol[i], 7'd0};          // vol * 128
            if (period[i] == 16'd0)
                ch_val[i] = 16'sd0;                  // silent channel
            else
                ch_val[i] = phase[i] ? amp[i] : -amp[i];
        end
        mix_l = (pan[0] ? ch_val[0] : 16'sd0) + (pan[2] ? ch_val[1] : 16'sd0);
        mix_r = (pan[1] ? ch_val[0] : 16'sd0) + (pan[3] ? ch_val[1] : 16'sd0);
    end

    always_comb begin
        case (reg_sel)
            REG_C0_PLO: rd_val = period[0][7:0];
            REG_C0_PHI: rd_val = period[0][15:8];
            REG_C0_VOL: rd_val = {1'b0, vol[0]};
            REG_C1_PLO: rd_val = period[1][7:0];
            REG_C1_PHI: rd_val = period[1][15:8];
            REG_C1_VOL: rd_val = {1'b0, vol[1]};
            REG_PAN:    rd_val = {4'd0, pan};
            default:    rd_val = 8'h00;
        endcase
    end
    assign dout = a0 ? rd_val : 8'h00;   // no status bits, no timers

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            reg_sel <= REG_C0_PLO;
            pan     <= '0;
            phase   <= '0;
            div     <= '0;
            sample  <= 1'b0;
            left    <= '0;
            right   <= '0;
            for (int i = 0; i < 2; i++) begin
                period[i] <= '0;
                vol[i]    <= '0;
                cnt[i]    <= '0;
            end
        end else begin
            sample <= tick;                           // one clk wide
            if (cen_fm)
                div <= tick ? '0 : div + 1'b1;
            if (tick) begin
                left  <= mix_l;                       // same edge as sample
                right <= mix_r;
                for (int i = 0; i < 2; i++) begin
                    if (period[i] == 16'd0) begin
                        cnt[i]   <= '0;
                        phase[i] <= 1'b0;
                    end else if (cnt[i] <= 16'd1) begin
                        cnt[i]   <= period[i];        // reload and flip
                        phase[i] <= ~phase[i];
                    end else begin
                        cnt[i] <= cnt[i] - 16'd1;
                    end
                end
            end
            if (cs && we) begin
                if (!a0)
                    reg_sel <= tone_reg_t'(din);
                else begin
                    case (reg_sel)
                        REG_C0_PLO: period[0][7:0]  <= din;
                        REG_C0_PHI: period[0][15:8] <= din;
                        REG_C0_VOL: vol[0]          <= din[6:0];
                        REG_C1_PLO: period[1][7:0]  <= din;
                        REG_C1_PHI: period[1][15:8] <= din;
                        REG_C1_VOL: vol[1]          <= din[6:0];
                        REG_PAN:    pan             <= din[3:0];
                        default: ;                    // unmapped register
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the sound board testbench with Verilator.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert --top-module snd_tb -f verilog.f -o snd_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! ./obj_dir/snd_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "simulation ended with an error status"
    exit 1
fi
cat "$LOG"

if grep -q "^All checks passed$" "$LOG"; then
    exit 0
fi
exit 1

// File: tests/snd_assert.sv
// concurrent checks on the sound board address decode, bound into every snd_decode
`default_nettype none

module snd_decode_assert (
    input wire                    clk,
    input wire                    rst_n,
    input wire snd_pkg::bus_req_t req,
    input wire                    rdy,
    input wire                    rom_cs,
    input wire                    ram_cs,
    input wire                    latch_cs,
    input wire                    tone_cs,
    input wire                    pcm_cs,
    input wire                    open_cs
);
    int fail_count = 0;   // assertion failures so far

    // one target per access
    a_one_select: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({rom_cs, ram_cs, latch_cs, tone_cs, pcm_cs, open_cs}))
        else begin
            fail_count++;
            $error("more than one chip select active");
        end

    a_rom_cs_reset: assert property (@(posedge clk) !rst_n |=> !rom_cs)
        else begin
            fail_count++;
            $error("rom_cs high in the cycle after reset");
        end

    // ready only answers a held request
    a_rdy_req: assert property (@(posedge clk) disable iff (!rst_n)
        rdy |-> (req.mreq || req.iorq))
        else begin
            fail_count++;
            $error("rdy without a memory or i/o request");
        end

endmodule

bind snd_decode snd_decode_assert u_decode_chk (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .req      ( req      ),
    .rdy      ( rdy      ),
    .rom_cs   ( rom_cs   ),
    .ram_cs   ( ram_cs   ),
    .latch_cs ( latch_cs ),
    .tone_cs  ( tone_cs  ),
    .pcm_cs   ( pcm_cs   ),
    .open_cs  ( open_cs  )
);

`default_nettype wire

// File: tests/snd_tb.sv
// sound board testbench: rom model with random wait states, directed tests, final pass or fail line
`default_nettype none

module snd_tb;
    import snd_pkg::*;

    localparam int TEST_COUNT      = 5;
    localparam int CYCLES_PER_TEST = 4000;
    localparam int WAIT_LIMIT      = 2000;   // cycles for one fetch wait
    localparam int TONE_P          = 3;
    localparam int TONE_V          = 20;
    localparam int RAM_X           = 'h35;

    logic              clk;
    logic              rst_n;
    logic              cen_fm = 1'b0;
    logic [7:0]        latch;
    logic              irqn;
    logic [7:0]        rom_data = 8'h00;
    logic              rom_ok = 1'b0;
    logic [ROM_AW-1:0] rom_addr;
    logic              rom_cs;
    logic signed [15:0] left;
    logic signed [15:0] right;
    logic              sample;

    logic [7:0]        rom [0:32767];
    logic [ROM_AW-1:0] fetch_q [$];          // start address of every rom access
    logic [ROM_AW-1:0] load_pc;
    logic [ROM_AW-1:0] loop_addr;
    logic [15:0]       lfsr = 16'd54079;
    logic [1:0]        cen_cnt = 2'd0;
    logic              cs_seen = 1'b0;
    int                wait_left = 0;
    int                errors = 0;
    int                checks = 0;
    int                fails;

    snd_top u_snd_top (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen_fm   ( cen_fm   ),
        .latch    ( latch    ),
        .irqn     ( irqn     ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .rom_addr ( rom_addr ),
        .rom_cs   ( rom_cs   ),
        .left     ( left     ),
        .right    ( right    ),
        .sample   ( sample   )
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(negedge clk) begin
        cen_cnt = cen_cnt + 2'd1;
        cen_fm  = (cen_cnt == 2'd3);         // one cycle in four
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // 0..3 wait cycles, one lfsr step per bit
    function automatic int rom_delay();
        logic [1:0] d;
        lfsr = lfsr_step(lfsr);
        d[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        d[1] = lfsr[0];
        return int'(d);
    endfunction

    // rom model, ok raised after the drawn delay while cs holds
    always @(negedge clk) begin
        if (rom_cs) begin
            if (!cs_seen) begin
                cs_seen = 1'b1;
                fetch_q.push_back(rom_addr);
                wait_left = rom_delay();
            end
            rom_data = rom[rom_addr];
            rom_ok   = (wait_left == 0);
            if (wait_left > 0)
                wait_left--;
        end else begin
            cs_seen = 1'b0;
            rom_ok  = 1'b0;
        end
    end

    task automatic check_addr(input string name, input logic [ROM_AW-1:0] got,
                              input logic [ROM_AW-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_sample(input string name, input logic signed [15:0] got,
                                input logic signed [15:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic logic signed [15:0] magnitude(input logic signed [15:0] v);
        return (v < 0) ? -v : v;
    endfunction

    task automatic put_instr(input op_t op, input logic [7:0] b1, input logic [7:0] b2);
        rom[load_pc]         = op;
        rom[load_pc + 15'd1] = b1;
        rom[load_pc + 15'd2] = b2;            // b2 is the address high byte
        load_pc = load_pc + 15'd3;
    endtask

    // register number to port 00, value to port 01
    task automatic put_reg(input tone_reg_t r, input logic [7:0] v);
        put_instr(OP_LDI, r, 8'h00);
        put_instr(OP_OUT, 8'h00, 8'h00);
        put_instr(OP_LDI, v, 8'h00);
        put_instr(OP_OUT, 8'h01, 8'h00);
    endtask

    task automatic put_loop();
        loop_addr = load_pc;                  // jump to itself
        put_instr(OP_JP, load_pc[7:0], {1'b0, load_pc[14:8]});
    endtask

    task automatic begin_test(input string name);
        @(negedge clk);
        rst_n = 1'b0;
        irqn  = 1'b0;
        latch = 8'h00;
        for (int i = 0; i < 32768; i++)
            rom[15'(i)] = 8'(i ^ (i >> 7));   // fill, never reached by a program
        load_pc = '0;
        $display("test: %s", name);
    endtask

    task automatic release_reset();
        repeat (10) @(negedge clk);
        fetch_q.delete();
        rst_n = 1'b1;
    endtask

    task automatic wait_count(input int n);
        int cycles;
        cycles = 0;
        while (fetch_q.size() < n && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (fetch_q.size() < n) begin
            $display("only %0d of %0d rom fetches seen at %0t", fetch_q.size(), n, $time);
            errors++;
        end
    endtask

    task automatic wait_fetch(input logic [ROM_AW-1:0] addr, input string what);
        int cycles;
        cycles = 0;
        while ((fetch_q.size() == 0 || fetch_q[$] != addr) && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= WAIT_LIMIT) begin
            $display("never reached the %s fetch at %h", what, addr);
            errors++;
        end
    endtask

    task automatic wait_sample();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!sample && cycles < 200);
        if (!sample) begin
            $display("no sample strobe within 200 cycles at %0t", $time);
            errors++;
        end
    endtask

    // walk the rom by the fetch rules: pc order, jp redirects
    task automatic check_fetch_order(input int n_instr);
        logic [ROM_AW-1:0] pc;
        logic [15:0]       target;
        pc = '0;
        wait_count(3 * n_instr);
        for (int n = 0; n < n_instr; n++) begin
            for (int k = 0; k < 3; k++)
                check_addr($sformatf("fetch %0d", 3 * n + k), fetch_q[3 * n + k],
                           pc + ROM_AW'(k));
            target = {rom[pc + 15'd2], rom[pc + 15'd1]};
            pc = (rom[pc] == OP_JP) ? target[ROM_AW-1:0] : pc + 15'd3;
        end
    endtask

    task automatic fetch_order_test();
        begin_test("fetch order after reset");
        put_instr(OP_NOP, 8'h00, 8'h00);
        put_instr(OP_LDI, 8'h5A, 8'h00);
        put_instr(OP_JP, 8'h00, 8'h01);       // to 0100
        load_pc = 15'h0100;
        put_instr(OP_NOP, 8'h00, 8'h00);
        put_loop();
        release_reset();
        @(negedge clk);
        check_sample("left", left, 16'sd0);
        check_sample("right", right, 16'sd0);
        check_count("sample", int'(sample), 0);
        check_fetch_order(8);
    endtask

    task automatic tone_test();
        logic signed [15:0] lv [$];
        logic signed [15:0] expv;
        int f;
        begin_test("tone channel 0 panned left");
        put_reg(REG_C0_PLO, 8'(TONE_P));
        put_reg(REG_C0_VOL, 8'(TONE_V));
        put_reg(REG_PAN, 8'h01);
        put_loop();
        release_reset();
        wait_fetch(loop_addr, "idle loop");
        repeat (2) wait_sample();             // pan lands at the next sample
        for (int i = 0; i < 13; i++) begin
            wait_sample();
            lv.push_back(left);
            check_sample("right", right, 16'sd0);
        end
        f = 0;
        for (int i = TONE_P; i >= 1; i--)
            if ((lv[i] < 0) != (lv[i - 1] < 0))
                f = i;                        // first sign change
        if (f == 0) begin
            $display("left kept its sign for more than %0d samples", TONE_P);
            errors++;
        end
        expv = 16'(TONE_V * 128);
        if (lv[f] < 0)
            expv = -expv;
        for (int i = 0; i < 13; i++) begin
            if (i < f)
                check_sample("left magnitude", magnitude(lv[i]), 16'(TONE_V * 128));
            else
                check_sample("left", lv[i], (((i - f) / TONE_P) % 2 == 0) ? expv : -expv);
        end
    endtask

    task automatic ram_round_trip_test();
        begin_test("work ram round trip");
        put_reg(REG_C1_PLO, 8'd2);
        put_reg(REG_PAN, 8'h08);              // ch1 right only
        put_instr(OP_LDI, REG_C1_VOL, 8'h00);
        put_instr(OP_OUT, 8'h00, 8'h00);
        put_instr(OP_LDI, 8'(RAM_X), 8'h00);
        put_instr(OP_ST, RAM_BASE[7:0], RAM_BASE[15:8]);
        put_instr(OP_LDI, 8'h00, 8'h00);      // clear a before the load
        put_instr(OP_LD, RAM_BASE[7:0], RAM_BASE[15:8]);
        put_instr(OP_OUT, 8'h01, 8'h00);
        put_loop();
        release_reset();
        wait_fetch(loop_addr, "idle loop");
        repeat (2) wait_sample();
        repeat (3) begin
            wait_sample();
            check_sample("right magnitude", magnitude(right), 16'(RAM_X * 128));
            check_sample("left", left, 16'sd0);
        end
    endtask

    task automatic take_nmi(input logic [7:0] cmd);
        int base;
        int idx;
        logic [ROM_AW-1:0] prev;
        logic [ROM_AW-1:0] resume;
        logic [15:0]       target;
        @(negedge clk);
        irqn = 1'b0;
        repeat (2) @(negedge clk);
        latch = cmd;
        irqn  = 1'b1;                         // rising edge
        @(posedge clk);
        base = ((fetch_q.size() + 2) / 3) * 3;
        wait_count(base + 4);
        // an instruction already begun at the edge runs to its end first
        idx = (fetch_q[base] == NMI_VEC[ROM_AW-1:0]) ? base : base + 3;
        check_addr("nmi entry fetch", fetch_q[idx], NMI_VEC[ROM_AW-1:0]);
        prev   = fetch_q[idx - 3];
        target = {rom[prev + 15'd2], rom[prev + 15'd1]};
        resume = (rom[prev] == OP_JP) ? target[ROM_AW-1:0] : prev + 15'd3;
        wait_count(idx + 10);
        check_addr("resume fetch", fetch_q[idx + 9], resume);   // after 3 handler instrs
        repeat (3) wait_sample();
        check_sample("left magnitude", magnitude(left), 16'({1'b0, cmd[6:0]} * 128));
    endtask

    task automatic nmi_test();
        int entries;
        begin_test("nmi and command latch");
        put_reg(REG_C0_PLO, 8'd2);
        put_reg(REG_PAN, 8'h01);
        put_instr(OP_LDI, REG_C0_VOL, 8'h00);
        put_instr(OP_OUT, 8'h00, 8'h00);      // handler writes data only
        put_loop();
        load_pc = NMI_VEC[ROM_AW-1:0];
        put_instr(OP_IN, 8'hC0, 8'h00);       // latch read clears the pending nmi
        put_instr(OP_OUT, 8'h01, 8'h00);
        put_instr(OP_RETN, 8'h00, 8'h00);
        release_reset();
        wait_fetch(loop_addr, "idle loop");
        take_nmi(8'hA5);
        take_nmi(8'h3C);                      // second edge taken again
        entries = 0;
        foreach (fetch_q[i])
            if (fetch_q[i] == NMI_VEC[ROM_AW-1:0])
                entries++;
        check_count("nmi entries", entries, 2);
    endtask

    task automatic open_bus_test();
        begin_test("open bus and register readback");
        put_reg(REG_C0_PLO, 8'd2);
        put_reg(REG_PAN, 8'h01);
        put_instr(OP_LDI, REG_C0_VOL, 8'h00);
        put_instr(OP_OUT, 8'h00, 8'h00);
        put_instr(OP_IN, 8'h80, 8'h00);       // pcm port, nothing fitted
        put_instr(OP_OUT, 8'h01, 8'h00);
        put_instr(OP_LDI, REG_PAN, 8'h00);
        put_instr(OP_OUT, 8'h00, 8'h00);
        put_instr(OP_IN, 8'h01, 8'h00);       // pan back through the data port
        put_instr(OP_OUT, 8'h01, 8'h00);
        put_loop();
        release_reset();
        wait_fetch(loop_addr, "idle loop");
        repeat (2) wait_sample();
        repeat (3) begin
            wait_sample();
            check_sample("left magnitude", magnitude(left), 16'(127 * 128));
            check_sample("right", right, 16'sd0);
        end
    endtask

    initial begin
        repeat (TEST_COUNT * CYCLES_PER_TEST) @(posedge clk);
        $display("watchdog expired after %0d cycles", TEST_COUNT * CYCLES_PER_TEST);
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        irqn  = 1'b0;
        latch = 8'h00;
        fetch_order_test();
        tone_test();
        ram_round_trip_test();
        nmi_test();
        open_bus_test();
        fails = errors + u_snd_top.u_decode.u_decode_chk.fail_count;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 u_snd_top.u_decode.u_decode_chk.fail_count);
        if (fails == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
design/snd_pkg.sv
design/snd_cpu.sv
design/snd_decode.sv
design/snd_ram.sv
design/tone_gen.sv
design/snd_top.sv
tests/snd_assert.sv
tests/snd_tb.sv
